// ==== Bender.yml ====
package:
  name: video_output

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/video_pkg.sv
      - hw/playfield_encoder.sv
      - hw/sprite_encoder.sv
      - hw/pixel_priority.sv
      - hw/colortable_ram.sv
      - hw/denise_colortable.sv
      - hw/video_output_top.sv
  - target: test
    include_dirs:
      - hw
      - bench
    files:
      - bench/tb_video_output.sv

// ==== bench/tb_video_model.svh ====
//**************************************************************************
// reference model for the colour output testbench, included in the tb module
// palette shadow, encoder and priority rules, expected rgb delay line
//**************************************************************************

`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

logic [31:0] rng_state = 32'h1340_cf35;    // xorshift state, fixed seed
logic [11:0] pal_hi [`VID_PAL_DEPTH];       // shadow of the high nibbles
logic [11:0] pal_lo [`VID_PAL_DEPTH];       // shadow of the low nibbles
logic [7:0]  last_rd_addr = 8'h00;          // entry read by the previous pixel
rgb_t        exp_q [$];                     // expected rgb, two pixels in flight
bit          valid_q [$];                   // entry known and worth checking

// xorshift32, one step per call
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// colour register write into the shadow palette
task automatic write_palette(input reg_write_t w, input logic [2:0] bank, input logic loct);
  logic [7:0] entry;
  entry = {bank, w.address[4:0]};
  // only bits 8..6 equal to the colour base decode
  if (({w.address, 1'b0} >> 6) == (`VID_COLOR_BASE >> 6)) begin
    pal_lo[entry] = w.data;
    if (!loct) pal_hi[entry] = w.data;   // loct keeps the high nibbles
  end
endtask

// single playfield passes the planes, dual picks front or back field
function automatic pf_pixel_t encode_playfield(input logic [5:0] bpl, input logic dual,
                                               input logic pf2_front);
  pf_pixel_t p1;
  pf_pixel_t p2;
  pf_pixel_t res;
  p1.index  = 6'(bpl[0] + 2 * bpl[2] + 4 * bpl[4]);        // colours 0..7
  p1.opaque = (p1.index != 0);
  p2.index  = 6'(8 + bpl[1] + 2 * bpl[3] + 4 * bpl[5]);    // colours 8..15
  p2.opaque = (p2.index != 8);
  if (!dual) begin
    res = '{index: bpl, opaque: (bpl != 0)};
  end else if (pf2_front) begin
    res = p2.opaque ? p2 : p1;
  end else begin
    res = p1.opaque ? p1 : p2;
  end
  return res;
endfunction

// first nonzero sprite from sprite 0 upwards
function automatic spr_pixel_t encode_sprites(input logic [15:0] spr);
  spr_pixel_t res;
  res = '0;
  for (int s = 0; s < `VID_SPRITES; s++) begin
    if (!res.opaque && spr[2*s +: 2] != 2'b00) begin
      res.opaque = 1'b1;
      res.pair   = 2'(s / 2);
      res.index  = 4'(4 * (s / 2) + spr[2*s +: 2]);         // offset in sprite block
    end
  end
  return res;
endfunction

// expected rgb for one pixel, from the palette as it stands at the read edge
task automatic predict_pixel(input logic [5:0] bpl, input logic [15:0] spr,
                             input video_ctrl_t c, input logic [7:0] xr, input bit check);
  pf_pixel_t  pf;
  spr_pixel_t sp;
  logic [7:0] sel;
  logic [7:0] addr;
  rgb_t       full;
  rgb_t       e;
  pf = encode_playfield(bpl, c.dual_pf, c.pf2_pri);
  sp = encode_sprites(spr);
  if (sp.opaque && (sp.pair < c.spr_pri || !pf.opaque)) sel = 8'(16 + sp.index);
  else if (pf.opaque) sel = 8'(pf.index);
  else sel = 8'h00;                                          // background
  sel  = sel ^ xr;
  addr = c.ehb_en ? (sel & 8'h1f) : sel;                     // ehb sees 0..31 only
  full.r = {pal_hi[addr][11:8], pal_lo[addr][11:8]};
  full.g = {pal_hi[addr][7:4], pal_lo[addr][7:4]};
  full.b = {pal_hi[addr][3:0], pal_lo[addr][3:0]};
  e = full;
  if (c.ehb_en && sel[5]) begin
    e.r = full.r >> 1;
    e.g = full.g >> 1;
    e.b = full.b >> 1;
  end
  last_rd_addr = addr;
  exp_q.push_back(e);
  valid_q.push_back(check);
endtask

`endif

// ==== bench/tb_video_output.sv ====
//**************************************************************************
// testbench for the colour output stage checking random pixels against a model
// run from the project file list with tb_video_output as top
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module tb_video_output import video_pkg::*; ();

  localparam int n_random = 300;     // cycles for tests 3 to 5
  localparam int n_mixed  = 2000;
  localparam int n_loct   = 32;      // loct writes and as many outside the block
  localparam int total_cycles = 3 + 2 * (256 + 2) + (2 * n_loct + 256 + 2)
                                + 3 * (n_random + 2) + (n_mixed + 2);
  localparam logic [7:0] color_reg = 8'(`VID_COLOR_BASE >> 1);  // address field of entry 0

  logic        clk;
  logic        reset;
  logic [5:0]  bpl_bits;
  logic [15:0] spr_bits;
  video_ctrl_t ctrl;
  logic [7:0]  bplxor;
  reg_write_t  reg_wr;
  logic        wr_strobe;
  rgb_t        rgb;
  int          checks = 0;
  int          errors = 0;
  int          base_checks = 0;     // counts at the start of the current test
  int          base_errors = 0;

  `include "tb_video_model.svh"

  video_output_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .bpl_bits  (bpl_bits),
    .spr_bits  (spr_bits),
    .ctrl      (ctrl),
    .bplxor    (bplxor),
    .reg_wr    (reg_wr),
    .wr_strobe (wr_strobe),
    .rgb       (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // watchdog covers the whole run plus a margin
  initial begin
    #(total_cycles * 4 + 400);
    $display("simulation timed out at %0t ns, tests did not finish", $time);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check_rgb(input rgb_t expected, input rgb_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t ns: rgb expected %06h, got %06h", $time, expected, actual);
    end
  endtask

  // one pixel per call entered just after a falling edge
  task automatic step(input logic [5:0] bpl, input logic [15:0] spr, input video_ctrl_t c,
                      input logic [7:0] xr, input reg_write_t w, input logic strobe,
                      input bit check);
    rgb_t e;
    bit   v;
    e = exp_q.pop_front();      // pixel from two cycles back
    v = valid_q.pop_front();
    if (v) check_rgb(e, rgb);
    bpl_bits  = bpl;
    spr_bits  = spr;
    ctrl      = c;
    bplxor    = xr;
    reg_wr    = w;
    wr_strobe = strobe;
    if (strobe) write_palette(w, c.bank, c.loct);   // write lands before the read
    predict_pixel(bpl, spr, c, xr, check);
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    repeat (n) step('0, '0, '0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic finish_test(input string name);
    int dc;
    int de;
    idle(2);                    // drain the pipeline into this test
    dc = checks - base_checks;
    de = errors - base_errors;
    $display("%s: %0d checks, %0d errors, %s", name, dc, de, (de == 0) ? "ok" : "bad");
    base_checks = checks;
    base_errors = errors;
  endtask

  // xor upper bits reach banks 2 to 7 so every entry is read
  task automatic read_all();
    for (int e = 0; e < `VID_PAL_DEPTH; e++) begin
      step(6'(e), '0, '0, {2'(e >> 6), 6'b0}, '0, 1'b0, 1'b1);
    end
  endtask

  task automatic fill_readback();
    video_ctrl_t c;
    logic [31:0] r;
    for (int e = 0; e < `VID_PAL_DEPTH; e++) begin
      r = next_rand();
      c = '0;
      c.bank = 3'(e >> 5);
      step('0, '0, c, '0, '{address: color_reg | 8'(e & 31), data: r[11:0]}, 1'b1, 1'b0);
    end
    idle(2);
    read_all();
    finish_test("palette fill and readback");
  endtask

  task automatic loct_and_decode();
    video_ctrl_t c;
    logic [31:0] r;
    logic [7:0]  a;
    for (int i = 0; i < n_loct; i++) begin
      r = next_rand();
      c = '0;
      c.loct = 1'b1;
      c.bank = r[14:12];
      step('0, '0, c, '0, '{address: color_reg | r[20:16], data: r[11:0]}, 1'b1, 1'b1);
    end
    for (int i = 0; i < n_loct; i++) begin
      r = next_rand();
      a = r[23:16];
      if (a[7:5] == color_reg[7:5]) a[7] = ~a[7];   // force a miss on the block
      c = '0;
      c.loct = r[24];
      c.bank = r[14:12];
      step('0, '0, c, '0, '{address: a, data: r[11:0]}, 1'b1, 1'b1);
    end
    read_all();
    finish_test("low nibble writes and decode");
  endtask

  task automatic dual_playfield_xor();
    video_ctrl_t c;
    logic [31:0] r;
    for (int i = 0; i < n_random; i++) begin
      r = next_rand();
      c = '0;
      c.dual_pf   = 1'b1;
      c.pf2_pri   = r[0];
      c.bplxor_hi = r[23:21];
      step(r[13:8], '0, c, r[23:16], '0, 1'b0, 1'b1);
    end
    finish_test("dual playfield and xor");
  endtask

  task automatic sprite_priority();
    video_ctrl_t c;
    logic [31:0] r;
    logic [15:0] spr;
    logic [5:0]  bpl;
    for (int i = 0; i < n_random; i++) begin
      r   = next_rand();
      spr = r[15:0] & r[31:16];
      r   = next_rand();
      spr = spr & r[15:0];        // sparse codes so higher sprites also win
      bpl = r[29:24];
      if (r[31:30] == 2'b00) bpl = '0;   // transparent playfield
      if (r[23:22] == 2'b00) spr = '0;   // no sprite, background can show
      c = '0;
      c.dual_pf = r[16];
      c.pf2_pri = r[17];
      c.spr_pri = 3'(i % 5);
      step(bpl, spr, c, '0, '0, 1'b0, 1'b1);
    end
    finish_test("sprite priority");
  endtask

  task automatic half_brite();
    video_ctrl_t c;
    logic [31:0] r;
    for (int i = 0; i < n_random; i++) begin
      r = next_rand();
      c = '0;
      c.ehb_en = 1'b1;
      c.bank   = r[2:0];          // bank only steers writes
      step(r[13:8], '0, c, r[23:16], '0, 1'b0, 1'b1);
    end
    finish_test("extra half brite");
  endtask

  task automatic mixed_random();
    video_ctrl_t c;
    logic [31:0] r;
    logic [31:0] q;
    reg_write_t  w;
    logic        strobe;
    for (int i = 0; i < n_mixed; i++) begin
      r = next_rand();
      q = next_rand();
      c = video_ctrl_t'(q[12:0]);
      w.address = q[20:13];
      if (q[21]) w.address[7:5] = color_reg[7:5];
      w.data = r[31:20];
      strobe = (q[23:22] == 2'b00);
      if (q[26:24] == 3'b000) begin
        // hit the entry the previous pixel reads at this edge
        c.bank    = last_rd_addr[7:5];
        w.address = color_reg | last_rd_addr[4:0];
        strobe    = 1'b1;
      end
      step(r[5:0], r[19:4] & q[31:16], c, r[27:20], w, strobe, 1'b1);
    end
    finish_test("mixed random run");
  endtask

  initial begin
    reset     = 1'b1;
    bpl_bits  = '0;
    spr_bits  = '0;
    ctrl      = '0;
    bplxor    = '0;
    reg_wr    = '0;
    wr_strobe = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) begin
      exp_q.push_back('0);        // reset pixels go unchecked
      valid_q.push_back(1'b0);
    end
    fill_readback();
    loct_and_decode();
    dual_playfield_xor();
    sprite_priority();
    half_brite();
    mixed_random();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/colortable_ram.sv ====
//**************************************************************************
// palette memory, one write and one read port, registered read
// each 12-bit half has its own write enable for low nibble palettes
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module colortable_ram (
  input  logic        clk,
  input  logic [7:0]  wr_addr,     // bank and entry
  input  logic        wr_en,       // decoded write strobe
  input  logic [1:0]  wr_half,     // bit 1 high half, bit 0 low half
  input  logic [11:0] wr_data_hi,  // high nibbles of r, g, b
  input  logic [11:0] wr_data_lo,  // low nibbles of r, g, b
  input  logic [7:0]  rd_addr,     // xored select
  output logic [11:0] rd_hi,
  output logic [11:0] rd_lo
);

  // two arrays so each half maps to a plain block ram
  logic [11:0] mem_hi [`VID_PAL_DEPTH];
  logic [11:0] mem_lo [`VID_PAL_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en && wr_half[1]) begin
      mem_hi[wr_addr] <= wr_data_hi;
    end
    if (wr_en && wr_half[0]) begin
      mem_lo[wr_addr] <= wr_data_lo;
    end
  end

  // read before write on an address collision
  always_ff @(posedge clk) begin
    rd_hi <= mem_hi[rd_addr];
    rd_lo <= mem_lo[rd_addr];
  end

endmodule

// ==== hw/denise_colortable.sv ====
//**************************************************************************
// colour table, register writes into the palette and select to rgb
// applies the select xor and extra half brite around the palette memory
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module denise_colortable import video_pkg::*; (
  input  logic        clk,
  input  reg_write_t  reg_wr,     // register address and data
  input  logic        wr_strobe,  // one cycle write pulse
  input  logic [7:0]  select,     // colour select from priority
  input  logic [7:0]  bplxor,     // select xor value
  input  logic [2:0]  bank,       // write bank
  input  logic        loct,       // write low nibbles only
  input  logic        ehb_en,     // extra half brite
  output rgb_t        rgb
);

  localparam logic [8:0] color_base = `VID_COLOR_BASE;

  logic [7:0]  select_xored;
  logic        reg_hit;     // address in the colour block
  logic [7:0]  wr_addr;
  logic        wr_en;
  logic [1:0]  wr_half;
  logic [7:0]  rd_addr;
  logic [11:0] rd_hi;
  logic [11:0] rd_lo;
  logic        ehb_sel;     // halve this pixel
  rgb_t        color;       // packed palette word

  assign select_xored = select ^ bplxor;

  // address field holds bits 8..1, so bits 8..6 sit in 7..5
  assign reg_hit = reg_wr.address[7:5] == color_base[8:6];
  assign wr_en   = reg_hit && wr_strobe;
  assign wr_addr = {bank, reg_wr.address[4:0]};   // bank picks 32 of 256
  assign wr_half = loct ? 2'b01 : 2'b11;          // loct leaves high nibbles

  // ehb reads only the first 32 entries
  assign rd_addr = ehb_en ? {3'b000, select_xored[4:0]} : select_xored;

  colortable_ram clut (
    .clk        (clk),
    .wr_addr    (wr_addr),
    .wr_en      (wr_en),
    .wr_half    (wr_half),
    .wr_data_hi (reg_wr.data),
    .wr_data_lo (reg_wr.data),
    .rd_addr    (rd_addr),
    .rd_hi      (rd_hi),
    .rd_lo      (rd_lo)
  );

  // half brite decision travels with the read data
  always_ff @(posedge clk) begin
    ehb_sel <= ehb_en && select_xored[5];
  end

  // interleave nibbles, high half first per component
  assign color.r = {rd_hi[11:8], rd_lo[11:8]};
  assign color.g = {rd_hi[7:4],  rd_lo[7:4]};
  assign color.b = {rd_hi[3:0],  rd_lo[3:0]};

  always_comb begin
    if (ehb_sel) begin
      // every component one step darker
      rgb.r = {1'b0, color.r[7:1]};
      rgb.g = {1'b0, color.g[7:1]};
      rgb.b = {1'b0, color.b[7:1]};
    end else begin
      rgb = color;
    end
  end

endmodule

// ==== hw/pixel_priority.sv ====
//**************************************************************************
// priority merge of playfield and sprite pixels into a colour select
// purely combinational, sits between the encoders and the colour table
//**************************************************************************

`timescale 1ns/1ns

module pixel_priority import video_pkg::*; (
  input  pf_pixel_t  pf_pixel,   // from playfield encoder
  input  spr_pixel_t spr_pixel,  // from sprite encoder
  input  logic [2:0] spr_pri,    // pair threshold
  output logic [7:0] select      // palette select, before xor
);

  logic       pair_front;  // sprite pair ranks above the playfield
  logic       spr_win;     // sprite shows
  logic [7:0] spr_color;   // sprite colour index
  logic [7:0] pf_color;    // playfield colour index

  // pair 0 beats the playfield once spr_pri is 1 or more
  assign pair_front = {1'b0, spr_pixel.pair} < spr_pri;

  // sprite shows in front, or through a transparent playfield
  assign spr_win = spr_pixel.opaque && (pair_front || !pf_pixel.opaque);

  // sprite colours start at 16, four per pair
  assign spr_color = {4'b0001, spr_pixel.index};

  // playfield index is already 0..63
  assign pf_color = {2'b00, pf_pixel.index};

  always_comb begin
    if (spr_win) begin
      select = spr_color;
    end else if (pf_pixel.opaque) begin
      select = pf_color;
    end else begin
      select = 8'h00;   // background colour
    end
  end

endmodule

// ==== hw/playfield_encoder.sv ====
//**************************************************************************
// playfield encoder, bitplane bits to a registered playfield pixel
// single playfield passes the six planes, dual picks the front field
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module playfield_encoder import video_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`VID_PLANES-1:0] bpl_bits,  // one bit per plane, plane 0 in bit 0
  input  logic                   dual_pf,   // dual playfield mode
  input  logic                   pf2_pri,   // playfield 2 in front
  output pf_pixel_t              pf_pixel   // registered result
);

  logic [2:0] pf1_bits;   // planes 0, 2, 4
  logic [2:0] pf2_bits;   // planes 1, 3, 5
  pf_pixel_t  pf1;
  pf_pixel_t  pf2;
  pf_pixel_t  front;
  pf_pixel_t  back;
  pf_pixel_t  pf_next;

  // split odd and even planes
  assign pf1_bits = {bpl_bits[4], bpl_bits[2], bpl_bits[0]};
  assign pf2_bits = {bpl_bits[5], bpl_bits[3], bpl_bits[1]};

  // field 1 uses colours 0..7, field 2 colours 8..15
  assign pf1 = '{index: {3'b000, pf1_bits}, opaque: |pf1_bits};
  assign pf2 = '{index: {3'b001, pf2_bits}, opaque: |pf2_bits};

  // pf2_pri swaps the fields
  assign front = pf2_pri ? pf2 : pf1;
  assign back  = pf2_pri ? pf1 : pf2;

  always_comb begin
    if (!dual_pf) begin
      pf_next.index  = bpl_bits;    // straight six bit index
      pf_next.opaque = |bpl_bits;
    end else if (front.opaque) begin
      pf_next = front;
    end else begin
      pf_next = back;               // back field shows through, maybe transparent
    end
  end

  // output register, transparent after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      pf_pixel <= '0;
    end else begin
      pf_pixel <= pf_next;
    end
  end

endmodule

// ==== hw/sprite_encoder.sv ====
//**************************************************************************
// sprite encoder, eight 2-bit sprite pixels to the winning sprite pixel
// lowest numbered sprite with a nonzero code wins, result is registered
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module sprite_encoder import video_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [2*`VID_SPRITES-1:0]  spr_bits,   // sprite n in bits 2n+1..2n
  output spr_pixel_t                 spr_pixel   // registered winner
);

  spr_pixel_t win;   // combinational winner
  logic [1:0] code;  // current sprite code in the scan

  // fixed priority scan
  // walk from the highest sprite down so the lowest nonzero one
  // is the last to overwrite the result
  always_comb begin
    win  = '0;
    code = 2'b00;
    for (int n = `VID_SPRITES - 1; n >= 0; n--) begin
      code = spr_bits[2*n +: 2];
      if (code != 2'b00) begin
        win.pair   = 2'(n / 2);        // sprites pair up 0/1, 2/3 ...
        win.index  = {2'(n / 2), code};
        win.opaque = 1'b1;
      end
    end
    win.unused = 1'b0;                 // spare bit stays clear
  end

  // output register
  always_ff @(posedge clk) begin
    if (reset) begin
      spr_pixel <= '0;                 // no sprite after reset
    end else begin
      spr_pixel <= win;
    end
  end

endmodule

// ==== hw/video_consts.svh ====
//**************************************************************************
// sizes and register addresses for the colour output stage
// included by the package and by any module that sizes ports or memories
//**************************************************************************

`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// number of bitplanes feeding the playfield encoder
`define VID_PLANES 6

// hardware sprites, two pixel bits each
`define VID_SPRITES 8

// palette entries, eight banks of 32
`define VID_PAL_DEPTH 256

// colour register block base
// register address bits 8 to 6 select the block, bits 5 to 1 the entry
`define VID_COLOR_BASE 9'h180

`endif

// ==== hw/video_output_top.sv ====
//**************************************************************************
// colour output stage top, both encoders, priority and colour table
// pixel inputs reach rgb two cycles later, one pixel per cycle
//**************************************************************************

`timescale 1ns/1ns

`include "video_consts.svh"

module video_output_top import video_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`VID_PLANES-1:0]    bpl_bits,
  input  logic [2*`VID_SPRITES-1:0] spr_bits,
  input  video_ctrl_t               ctrl,       // level, applies with the pixel
  input  logic [7:0]                bplxor,     // level, applies with the pixel
  input  reg_write_t                reg_wr,
  input  logic                      wr_strobe,  // palette write pulse
  output rgb_t                      rgb
);

  pf_pixel_t   pf_pixel;
  spr_pixel_t  spr_pixel;
  logic [7:0]  select;
  video_ctrl_t ctrl_d;     // ctrl one cycle late, lines up with encoded pixel
  logic [7:0]  bplxor_d;

  // encoders take dual_pf and pf2_pri with the raw pixel
  playfield_encoder pf_enc (
    .clk      (clk),
    .reset    (reset),
    .bpl_bits (bpl_bits),
    .dual_pf  (ctrl.dual_pf),
    .pf2_pri  (ctrl.pf2_pri),
    .pf_pixel (pf_pixel)
  );

  sprite_encoder spr_enc (
    .clk       (clk),
    .reset     (reset),
    .spr_bits  (spr_bits),
    .spr_pixel (spr_pixel)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_d   <= '0;
      bplxor_d <= 8'h00;
    end else begin
      ctrl_d   <= ctrl;
      bplxor_d <= bplxor;
    end
  end

  pixel_priority prio (
    .pf_pixel  (pf_pixel),
    .spr_pixel (spr_pixel),
    .spr_pri   (ctrl_d.spr_pri),
    .select    (select)
  );

  // bank and loct steer writes, so they go with the undelayed strobe
  denise_colortable ctab (
    .clk       (clk),
    .reg_wr    (reg_wr),
    .wr_strobe (wr_strobe),
    .select    (select),
    .bplxor    (bplxor_d),
    .bank      (ctrl.bank),
    .loct      (ctrl.loct),
    .ehb_en    (ctrl_d.ehb_en),
    .rgb       (rgb)
  );

endmodule

// ==== hw/video_pkg.sv ====
//**************************************************************************
// shared types for the colour output stage
// imported by the RTL and the testbench
//**************************************************************************

package video_pkg;

  `include "video_consts.svh"

  // playfield pixel after the encoder
  typedef struct packed {
    logic [`VID_PLANES-1:0] index;  // colour index 0..63
    logic                   opaque; // any plane bit set
  } pf_pixel_t;

  // winning sprite pixel
  typedef struct packed {
    logic [3:0] index;   // offset in sprite block, {pair, code}
    logic [1:0] pair;    // sprite pair of the winner
    logic       unused;  // spare, kept at zero
    logic       opaque;  // nonzero sprite code found
  } spr_pixel_t;

  // register bus write
  typedef struct packed {
    logic [7:0]  address;  // register address bits 8..1
    logic [11:0] data;     // 12-bit colour word
  } reg_write_t;

  // 24-bit colour out
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // display control levels
  typedef struct packed {
    logic       dual_pf;   // dual playfield mode
    logic       pf2_pri;   // playfield 2 in front
    logic [2:0] spr_pri;   // sprite pairs below this beat the playfield
    logic       ehb_en;    // extra half brite
    logic       loct;      // low nibble palette writes
    logic [2:0] bank;      // palette bank for writes
    logic [2:0] bplxor_hi; // upper xor bits, full xor has its own port
  } video_ctrl_t;

endpackage

// ==== project.f ====
+incdir+hw
+incdir+bench
hw/video_pkg.sv
hw/playfield_encoder.sv
hw/sprite_encoder.sv
hw/pixel_priority.sv
hw/colortable_ram.sv
hw/denise_colortable.sv
hw/video_output_top.sv
bench/tb_video_output.sv
